//--- project.f
+incdir+bench
common/cp0_pkg.sv
verilog/exc_arbiter.sv
cp0/cp0_reg.sv
cp0/cp0_apb_port.sv
verilog/exc_subsystem.sv
bench/tb_exc_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# build with verilator, then look for the pass line in the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_exc_subsystem -o tb_exc_subsystem -f project.f \
   && ./obj_dir/tb_exc_subsystem | tee /dev/stderr | grep -qx "Result: PASSED" \
   && echo "simulation ok" \
   || { echo "simulation failed"; exit 1; }

//--- bench/exc_checks.svh
`ifndef EXC_CHECKS_SVH
`define EXC_CHECKS_SVH

// sampled on the rising edge, stimulus moves on the falling edge

a_reset_idle: assert property (@(posedge clk)
   after_rst |-> !flush && !timer_int && !pready && !pslverr)
   else abort_test("outputs are not idle in the first cycle after reset");

a_flush_value: assert property (@(posedge clk) disable iff (rst)
   flush_chk |-> flush == exp_flush)
   else show_mismatch("flush_o", 32'(exp_flush), 32'($sampled(flush)));

a_target_value: assert property (@(posedge clk) disable iff (rst)
   (flush_chk && exp_flush) |-> target_pc == exp_target)
   else show_mismatch("target_pc_o", exp_target, $sampled(target_pc));

// a flush stalls any access cycle
a_no_ready_in_flush: assert property (@(posedge clk) disable iff (rst)
   flush |-> !pready)
   else abort_test("an APB transfer completed in the same cycle as a flush");

a_read_data: assert property (@(posedge clk) disable iff (rst)
   (rd_chk && pready) |-> prdata == exp_rdata)
   else show_mismatch("prdata_o", exp_rdata, $sampled(prdata));

a_read_error: assert property (@(posedge clk) disable iff (rst)
   (err_chk && pready) |-> pslverr == exp_err)
   else show_mismatch("pslverr_o", 32'(exp_err), 32'($sampled(pslverr)));

a_timer_quiet: assert property (@(posedge clk) disable iff (rst)
   timer_off |-> !timer_int)   // outside the allowed rise window
   else show_mismatch("timer_int_o", 32'd0, 32'($sampled(timer_int)));

`endif

//--- bench/tb_exc_subsystem.sv
`timescale 1ns/1ps

module tb_exc_subsystem;
   import cp0_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int RST_CYCLES = 3;
   localparam int N_SINGLE = 10;
   localparam int N_MULTI = 4;
   localparam int MAX_N = 20;
   localparam int TEST_CYCLES = 25 + N_SINGLE * 18 + N_MULTI * 36 + 50 + 2 * MAX_N + 20;
   localparam int MARGIN = 200;

   logic clk = 1'b0;
   logic rst, commit_valid, commit_ds, commit_eret, flush, timer_int;
   logic psel, penable, pwrite, pready, pslverr;
   word_t commit_pc, commit_badvaddr, target_pc, pwdata, prdata;
   exc_flags_t commit_flags;
   logic [5:0] ext_int;
   logic [6:0] paddr;

   // check enables and expected values
   logic flush_chk, exp_flush, rd_chk, err_chk, exp_err, after_rst, timer_off;
   word_t exp_target, exp_rdata;
   // shadow cp0 state
   logic m_exl, m_bd, m_ie, m_bad_ok;
   logic [7:0] m_im;
   exc_code_t m_code;
   word_t m_epc, m_bad;
   logic [31:0] rnd;
   int cyc = 0;

   exc_subsystem exc_subsystem_i (
      .clk (clk), .rst (rst),
      .commit_valid_i (commit_valid), .commit_pc_i (commit_pc),
      .commit_in_delay_slot_i (commit_ds), .commit_flags_i (commit_flags),
      .commit_eret_i (commit_eret), .commit_badvaddr_i (commit_badvaddr),
      .ext_int_i (ext_int), .flush_o (flush), .target_pc_o (target_pc),
      .timer_int_o (timer_int), .psel_i (psel), .penable_i (penable),
      .pwrite_i (pwrite), .paddr_i (paddr), .pwdata_i (pwdata), .prdata_o (prdata),
      .pready_o (pready), .pslverr_o (pslverr)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;
   always @(posedge clk) cyc <= cyc + 1;

   task automatic show_mismatch(input string name, input word_t exp_v, input word_t act_v);
      $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, exp_v, act_v);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", name);
   endtask

   task automatic abort_test(input string msg);
      $display("at %0d ns: %s", $time, msg);
      $display("Result: FAILED");
      $fatal(1, "%s", msg);
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   // interrupt first, then flags from bit 0 up
   function automatic exc_code_t pick_code(input exc_flags_t f, input logic irq);
      if (irq) return EXC_INT;
      if (f[0]) return EXC_ADEL;
      if (f[1]) return EXC_RI;
      if (f[2]) return EXC_SYS;
      if (f[3]) return EXC_BP;
      if (f[4]) return EXC_OV;
      if (f[5]) return EXC_ADEL;
      return EXC_ADES;
   endfunction

   function automatic word_t status_model();
      return STATUS_RESET | {16'd0, m_im, 6'd0, m_exl, m_ie};
   endfunction

   function automatic word_t cause_model();
      return {m_bd, 1'b0, 14'd0, ext_int, 2'b00, 1'b0, m_code, 2'b00};
   endfunction

   task automatic apb_xfer(input logic wr, input cp0_addr_t r, input word_t data);
      @(negedge clk);
      psel = 1'b1;
      pwrite = wr;
      paddr = {r, 2'b00};
      pwdata = data;
      @(negedge clk);
      penable = 1'b1;
      #1;
      while (!pready) begin   // wait states while a flush is in progress
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_expect(input cp0_addr_t r, input word_t val, input logic err);
      rd_chk = !err;
      err_chk = 1'b1;
      exp_rdata = val;
      exp_err = err;
      apb_xfer(1'b0, r, '0);
      rd_chk = 1'b0;
      err_chk = 1'b0;
   endtask

   task automatic commit_insn(input exc_flags_t flags, input logic eret);
      logic irq, take;
      @(negedge clk);
      rnd = xorshift(rnd);
      commit_pc = {rnd[31:2], 2'b00};
      commit_ds = rnd[1];
      rnd = xorshift(rnd);
      commit_badvaddr = rnd;
      commit_flags = flags;
      commit_eret = eret;
      commit_valid = 1'b1;
      irq = m_ie && !m_exl && |({ext_int, 2'b00} & m_im);
      take = irq || |flags;
      flush_chk = 1'b1;
      exp_flush = take || eret;
      exp_target = take ? HANDLER_PC : m_epc;
      if (take) begin
         m_code = pick_code(flags, irq);
         if (!m_exl) begin   // nested exception keeps epc and bd
            m_epc = commit_ds ? commit_pc - 32'd4 : commit_pc;
            m_bd = commit_ds;
         end
         m_exl = 1'b1;
         if (!irq && (m_code == EXC_ADEL || m_code == EXC_ADES)) begin
            m_bad = flags[0] ? commit_pc : commit_badvaddr;
            m_bad_ok = 1'b1;
         end
      end else if (eret) begin
         m_exl = 1'b0;
      end
      @(negedge clk);
      commit_valid = 1'b0;
      flush_chk = 1'b0;
   endtask

   task automatic check_state();
      read_expect(CP0_REG_EPC, m_epc, 1'b0);
      read_expect(CP0_REG_CAUSE, cause_model(), 1'b0);
      read_expect(CP0_REG_STATUS, status_model(), 1'b0);
      if (m_bad_ok) read_expect(CP0_REG_BADVADDR, m_bad, 1'b0);
   endtask

   `include "exc_checks.svh"

   initial begin
      #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
      abort_test("watchdog expired before the tests finished");
   end

   initial begin
      exc_flags_t flags;
      int k, n, c0;
      word_t wval;
      rst = 1'b1;
      {commit_valid, commit_ds, commit_eret, commit_flags} = '0;
      {commit_pc, commit_badvaddr, ext_int} = '0;
      {psel, penable, pwrite, paddr, pwdata} = '0;
      {flush_chk, exp_flush, rd_chk, err_chk, exp_err, after_rst} = '0;
      {exp_target, exp_rdata} = '0;
      timer_off = 1'b1;
      {m_exl, m_bd, m_ie, m_bad_ok, m_im, m_epc, m_bad} = '0;
      m_code = EXC_INT;
      rnd = 32'd32;
      repeat (RST_CYCLES) @(negedge clk);
      rst = 1'b0;
      after_rst = 1'b1;
      @(negedge clk);
      after_rst = 1'b0;

      read_expect(CP0_REG_STATUS, STATUS_RESET, 1'b0);
      read_expect(CP0_REG_PRID, PRID_VALUE, 1'b0);
      read_expect(CP0_REG_CONFIG, CONFIG_VALUE, 1'b0);
      read_expect(CP0_REG_CAUSE, '0, 1'b0);
      read_expect(CP0_REG_EPC, '0, 1'b0);
      read_expect(5'd3, '0, 1'b1);   // not implemented

      repeat (N_SINGLE) begin
         rnd = xorshift(rnd);
         commit_insn(exc_flags_t'(7'd1 << (rnd % 7)), 1'b0);
         check_state();
         commit_insn('0, 1'b1);
      end

      repeat (N_MULTI) begin
         rnd = xorshift(rnd);
         flags = rnd[6:0] | (7'd3 << (rnd[10:8] % 6));   // at least two flags
         commit_insn(flags, 1'b0);
         check_state();
         commit_insn(exc_flags_t'(7'd1 << (rnd[14:12] % 7)), 1'b0);   // nested
         check_state();
         commit_insn(exc_flags_t'(7'd1 << (rnd[18:16] % 7)), 1'b1);   // eret loses
         commit_insn('0, 1'b1);
         read_expect(CP0_REG_STATUS, status_model(), 1'b0);
      end

      // external interrupt on one line
      rnd = xorshift(rnd);
      k = rnd % 6;
      ext_int = 6'd1 << k;
      m_ie = 1'b1;
      m_im = 8'd4 << k;
      apb_xfer(1'b1, CP0_REG_STATUS, status_model());
      wval = {rnd[31:2], 2'b00} ^ 32'h0000_1230;
      fork
         apb_xfer(1'b1, CP0_REG_EPC, wval);
         begin
            @(negedge clk);
            commit_insn('0, 1'b0);
         end
      join
      m_epc = wval;   // write lands after the flush
      check_state();
      commit_insn('0, 1'b1);
      m_im = '0;
      apb_xfer(1'b1, CP0_REG_STATUS, status_model());
      commit_insn('0, 1'b0);   // masked, no flush
      ext_int = '0;
      m_ie = 1'b0;
      apb_xfer(1'b1, CP0_REG_STATUS, status_model());

      // timer against compare
      rnd = xorshift(rnd);
      n = 8 + rnd % (MAX_N - 7);
      apb_xfer(1'b1, CP0_REG_COUNT, '0);
      c0 = cyc;
      apb_xfer(1'b1, CP0_REG_COMPARE, word_t'(n));
      while (!timer_int && cyc - c0 <= 2 * n + 4) begin
         if (cyc - c0 >= 2 * n - 2) timer_off = 1'b0;
         @(negedge clk);
      end
      assert (timer_int) else abort_test("timer interrupt did not rise within 2N+4 cycles");
      apb_xfer(1'b1, CP0_REG_COMPARE, '0);
      timer_off = 1'b1;
      repeat (2) @(negedge clk);

      $display("Result: PASSED");
      $finish;
   end

endmodule

//--- verilog/exc_subsystem.sv
`timescale 1ns/1ps

module exc_subsystem (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 commit_valid_i,
   input  cp0_pkg::word_t       commit_pc_i,
   input  logic                 commit_in_delay_slot_i,
   input  cp0_pkg::exc_flags_t  commit_flags_i,
   input  logic                 commit_eret_i,
   input  cp0_pkg::word_t       commit_badvaddr_i,
   input  logic [5:0]           ext_int_i,
   output logic                 flush_o,
   output cp0_pkg::word_t       target_pc_o,
   output logic                 timer_int_o,
   input  logic                 psel_i,
   input  logic                 penable_i,
   input  logic                 pwrite_i,
   input  logic [6:0]           paddr_i,
   input  cp0_pkg::word_t       pwdata_i,
   output cp0_pkg::word_t       prdata_o,
   output logic                 pready_o,
   output logic                 pslverr_o
);
   import cp0_pkg::*;

   logic       exc_take;
   logic       exc_eret;
   exc_code_t  exc_code;
   word_t      exc_badvaddr;
   logic       exc_busy;
   word_t      status;
   word_t      cause;
   word_t      epc;
   logic       cp0_we;
   cp0_addr_t  cp0_addr;   // shared by write and read side
   word_t      cp0_wdata;
   word_t      cp0_rdata;
   logic       cp0_rvalid;

   exc_arbiter exc_arbiter_i (
      .commit_valid_i         (commit_valid_i),
      .commit_pc_i            (commit_pc_i),
      .commit_in_delay_slot_i (commit_in_delay_slot_i),
      .commit_flags_i         (commit_flags_i),
      .commit_eret_i          (commit_eret_i),
      .commit_badvaddr_i      (commit_badvaddr_i),
      .status_i               (status),
      .cause_i                (cause),
      .epc_i                  (epc),
      .exc_take_o             (exc_take),
      .exc_eret_o             (exc_eret),
      .exc_code_o             (exc_code),
      .exc_badvaddr_o         (exc_badvaddr),
      .flush_o                (flush_o),
      .target_pc_o            (target_pc_o),
      .busy_o                 (exc_busy)
   );

   cp0_reg cp0_reg_i (
      .clk                 (clk),
      .rst                 (rst),
      .ext_int_i           (ext_int_i),
      .exc_take_i          (exc_take),
      .exc_eret_i          (exc_eret),
      .exc_code_i          (exc_code),
      .exc_pc_i            (commit_pc_i),
      .exc_in_delay_slot_i (commit_in_delay_slot_i),
      .exc_badvaddr_i      (exc_badvaddr),
      .we_i                (cp0_we),
      .waddr_i             (cp0_addr),
      .wdata_i             (cp0_wdata),
      .raddr_i             (cp0_addr),
      .rdata_o             (cp0_rdata),
      .rvalid_o            (cp0_rvalid),
      .status_o            (status),
      .cause_o             (cause),
      .epc_o               (epc),
      .timer_int_o         (timer_int_o)
   );

   cp0_apb_port cp0_apb_port_i (
      .clk          (clk),
      .rst          (rst),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .pwrite_i     (pwrite_i),
      .paddr_i      (paddr_i),
      .pwdata_i     (pwdata_i),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o),
      .exc_busy_i   (exc_busy),
      .cp0_we_o     (cp0_we),
      .cp0_addr_o   (cp0_addr),
      .cp0_wdata_o  (cp0_wdata),
      .cp0_rdata_i  (cp0_rdata),
      .cp0_rvalid_i (cp0_rvalid)
   );

endmodule

//--- cp0/cp0_apb_port.sv
`timescale 1ns/1ps

module cp0_apb_port (
   input  logic                clk,
   input  logic                rst,
   input  logic                psel_i,
   input  logic                penable_i,
   input  logic                pwrite_i,
   input  logic [6:0]          paddr_i,
   input  cp0_pkg::word_t      pwdata_i,
   output cp0_pkg::word_t      prdata_o,
   output logic                pready_o,
   output logic                pslverr_o,
   input  logic                exc_busy_i,
   output logic                cp0_we_o,
   output cp0_pkg::cp0_addr_t  cp0_addr_o,
   output cp0_pkg::word_t      cp0_wdata_o,
   input  cp0_pkg::word_t      cp0_rdata_i,
   input  logic                cp0_rvalid_i
);

   logic access;
   logic err_q;

   assign access     = psel_i & penable_i;
   assign pready_o   = access & ~exc_busy_i;   // wait state during a flush
   assign cp0_addr_o = paddr_i[6:2];
   assign cp0_wdata_o = pwdata_i;

   // one pulse per completed write, unknown registers dropped
   assign cp0_we_o = pready_o & pwrite_i & cp0_rvalid_i;

   assign prdata_o = (pready_o & ~pwrite_i) ? cp0_rdata_i : '0;

   // error decided in setup, address is held until completion
   always_ff @(posedge clk) begin
      if (rst) begin
         err_q <= 1'b0;
      end else if (psel_i && !penable_i) begin
         err_q <= ~cp0_rvalid_i;
      end else if (pready_o) begin
         err_q <= 1'b0;
      end
   end

   assign pslverr_o = pready_o & err_q;

   a_penable_with_psel: assert property (
      @(posedge clk) disable iff (rst) penable_i |-> psel_i)
      else $error("cp0_apb_port: penable without psel");

endmodule

//--- cp0/cp0_reg.sv
`timescale 1ns/1ps

module cp0_reg (
   input  logic                clk,
   input  logic                rst,
   input  logic [5:0]          ext_int_i,
   input  logic                exc_take_i,
   input  logic                exc_eret_i,
   input  cp0_pkg::exc_code_t  exc_code_i,
   input  cp0_pkg::word_t      exc_pc_i,
   input  logic                exc_in_delay_slot_i,
   input  cp0_pkg::word_t      exc_badvaddr_i,
   input  logic                we_i,
   input  cp0_pkg::cp0_addr_t  waddr_i,
   input  cp0_pkg::word_t      wdata_i,
   input  cp0_pkg::cp0_addr_t  raddr_i,
   output cp0_pkg::word_t      rdata_o,
   output logic                rvalid_o,
   output cp0_pkg::word_t      status_o,
   output cp0_pkg::word_t      cause_o,
   output cp0_pkg::word_t      epc_o,
   output logic                timer_int_o
);
   import cp0_pkg::*;

   logic [32:0] count_q;   // lsb is the divide-by-two prescaler
   word_t       count;
   word_t       compare_q;
   word_t       status_q;
   word_t       epc_q;
   word_t       badvaddr_q;
   logic        bd_q;
   logic        timer_int_q;
   logic [1:0]  ip_sw_q;
   logic [5:0]  ip_hw_q;
   exc_code_t   exc_code_q;
   logic        addr_exc;

   assign count    = count_q[32:1];
   assign addr_exc = (exc_code_i == EXC_ADEL) || (exc_code_i == EXC_ADES);

   always_ff @(posedge clk) begin
      if (rst) begin
         count_q     <= '0;
         compare_q   <= '0;
         status_q    <= STATUS_RESET;
         epc_q       <= '0;
         bd_q        <= 1'b0;
         timer_int_q <= 1'b0;
         ip_sw_q     <= '0;
         ip_hw_q     <= '0;
         exc_code_q  <= EXC_INT;
      end else begin
         count_q <= count_q + 33'd1;
         // ip7 shares its line with the timer
         ip_hw_q <= {ext_int_i[5] | timer_int_q, ext_int_i[4:0]};
         if (compare_q != '0 && count == compare_q) begin
            timer_int_q <= 1'b1;
         end

         if (exc_take_i) begin
            status_q[EXL_BIT] <= 1'b1;
            exc_code_q        <= exc_code_i;
            // nested exception keeps the first epc
            if (!status_q[EXL_BIT]) begin
               epc_q <= exc_in_delay_slot_i ? exc_pc_i - 32'd4 : exc_pc_i;
               bd_q  <= exc_in_delay_slot_i;
            end
         end else if (exc_eret_i) begin
            status_q[EXL_BIT] <= 1'b0;
         end else if (we_i) begin
            case (waddr_i)
               CP0_REG_COUNT: count_q <= {wdata_i, 1'b0};
               CP0_REG_COMPARE: begin
                  compare_q   <= wdata_i;
                  timer_int_q <= 1'b0;   // acknowledge
               end
               CP0_REG_STATUS:
                  status_q <= (status_q & ~STATUS_WMASK) | (wdata_i & STATUS_WMASK);
               CP0_REG_CAUSE: ip_sw_q <= wdata_i[IP_LO+1:IP_LO];
               CP0_REG_EPC: epc_q <= wdata_i;
               default: ;   // read-only or not implemented
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (exc_take_i && addr_exc) begin
         badvaddr_q <= exc_badvaddr_i;
      end
   end

   assign status_o = status_q | (word_t'(1) << BEV_BIT);   // bev hard-wired
   assign epc_o    = epc_q;
   assign timer_int_o = timer_int_q;

   always_comb begin
      cause_o                     = '0;
      cause_o[BD_BIT]             = bd_q;
      cause_o[TI_BIT]             = timer_int_q;
      cause_o[IP_HI:IP_LO+2]      = ip_hw_q;
      cause_o[IP_LO+1:IP_LO]      = ip_sw_q;
      cause_o[EXC_HI:EXC_LO]      = exc_code_q;
   end

   // mfc0 path
   always_comb begin
      rdata_o  = '0;
      rvalid_o = 1'b1;
      case (raddr_i)
         CP0_REG_BADVADDR: rdata_o = badvaddr_q;
         CP0_REG_COUNT:    rdata_o = count;
         CP0_REG_COMPARE:  rdata_o = compare_q;
         CP0_REG_STATUS:   rdata_o = status_o;
         CP0_REG_CAUSE:    rdata_o = cause_o;
         CP0_REG_EPC:      rdata_o = epc_q;
         CP0_REG_PRID:     rdata_o = PRID_VALUE;
         CP0_REG_CONFIG:   rdata_o = CONFIG_VALUE;
         default:          rvalid_o = 1'b0;
      endcase
   end

   // apb back-pressure must keep writes away from exception recording
   a_no_write_on_exc: assert property (
      @(posedge clk) disable iff (rst) !(we_i && (exc_take_i || exc_eret_i)))
      else $error("cp0_reg: write to reg %0d collides with exception commit", waddr_i);

endmodule

//--- verilog/exc_arbiter.sv
`timescale 1ns/1ps

module exc_arbiter (
   input  logic                 commit_valid_i,
   input  cp0_pkg::word_t       commit_pc_i,
   input  logic                 commit_in_delay_slot_i,
   input  cp0_pkg::exc_flags_t  commit_flags_i,
   input  logic                 commit_eret_i,
   input  cp0_pkg::word_t       commit_badvaddr_i,
   input  cp0_pkg::word_t       status_i,
   input  cp0_pkg::word_t       cause_i,
   input  cp0_pkg::word_t       epc_i,
   output logic                 exc_take_o,
   output logic                 exc_eret_o,
   output cp0_pkg::exc_code_t   exc_code_o,
   output cp0_pkg::word_t       exc_badvaddr_o,
   output logic                 flush_o,
   output cp0_pkg::word_t       target_pc_o,
   output logic                 busy_o
);
   import cp0_pkg::*;

   logic [7:0] int_vec;
   logic       int_pending;

   assign int_vec     = cause_i[IP_HI:IP_LO] & status_i[IM_HI:IM_LO];
   assign int_pending = status_i[IE_BIT] & ~status_i[EXL_BIT] & (|int_vec);

   // interrupt first, then flags in bit order
   always_comb begin
      exc_take_o     = 1'b0;
      exc_code_o     = EXC_INT;
      exc_badvaddr_o = commit_badvaddr_i;
      if (commit_valid_i) begin
         exc_take_o = 1'b1;
         if (int_pending) begin
            exc_code_o = EXC_INT;
         end else if (commit_flags_i[FLAG_IF_ADEL]) begin
            exc_code_o     = EXC_ADEL;
            exc_badvaddr_o = commit_pc_i;   // fetch fault reports the pc
         end else if (commit_flags_i[FLAG_RI]) begin
            exc_code_o = EXC_RI;
         end else if (commit_flags_i[FLAG_SYS]) begin
            exc_code_o = EXC_SYS;
         end else if (commit_flags_i[FLAG_BP]) begin
            exc_code_o = EXC_BP;
         end else if (commit_flags_i[FLAG_OV]) begin
            exc_code_o = EXC_OV;
         end else if (commit_flags_i[FLAG_D_ADEL]) begin
            exc_code_o = EXC_ADEL;
         end else if (commit_flags_i[FLAG_D_ADES]) begin
            exc_code_o = EXC_ADES;
         end else begin
            exc_take_o = 1'b0;
         end
      end
   end

   // eret only wins when nothing else is taken
   assign exc_eret_o = commit_valid_i & commit_eret_i & ~exc_take_o;

   assign flush_o     = exc_take_o | exc_eret_o;
   assign target_pc_o = exc_eret_o ? epc_i : HANDLER_PC;
   assign busy_o      = flush_o;   // holds off mtc0 writes this cycle

endmodule

//--- common/cp0_pkg.sv
package cp0_pkg;

   // data and address word
   typedef logic [31:0] word_t;

   // cp0 register number, paddr bits 6:2
   typedef logic [4:0] cp0_addr_t;

   typedef logic [4:0] exc_code_t;   // cause ExcCode field

   // commit-stage flags, bit 0 has the highest priority
   typedef logic [6:0] exc_flags_t;

   localparam int FLAG_IF_ADEL = 0;  // fetch address error
   localparam int FLAG_RI      = 1;
   localparam int FLAG_SYS     = 2;
   localparam int FLAG_BP      = 3;
   localparam int FLAG_OV      = 4;
   localparam int FLAG_D_ADEL  = 5;  // load address error
   localparam int FLAG_D_ADES  = 6;  // store address error

   // register numbers
   localparam cp0_addr_t CP0_REG_BADVADDR = 5'd8;
   localparam cp0_addr_t CP0_REG_COUNT    = 5'd9;
   localparam cp0_addr_t CP0_REG_COMPARE  = 5'd11;
   localparam cp0_addr_t CP0_REG_STATUS   = 5'd12;
   localparam cp0_addr_t CP0_REG_CAUSE    = 5'd13;
   localparam cp0_addr_t CP0_REG_EPC      = 5'd14;
   localparam cp0_addr_t CP0_REG_PRID     = 5'd15;
   localparam cp0_addr_t CP0_REG_CONFIG   = 5'd16;

   // status fields
   localparam int IE_BIT  = 0;
   localparam int EXL_BIT = 1;
   localparam int BEV_BIT = 22;
   localparam int IM_LO   = 8;
   localparam int IM_HI   = 15;

   // cause fields
   localparam int BD_BIT  = 31;
   localparam int TI_BIT  = 30;
   localparam int IP_LO   = 8;   // ip1..0 software, ip7..2 hardware
   localparam int IP_HI   = 15;
   localparam int EXC_LO  = 2;
   localparam int EXC_HI  = 6;

   // exception codes
   localparam exc_code_t EXC_INT  = 5'd0;
   localparam exc_code_t EXC_ADEL = 5'd4;
   localparam exc_code_t EXC_ADES = 5'd5;
   localparam exc_code_t EXC_SYS  = 5'd8;
   localparam exc_code_t EXC_BP   = 5'd9;
   localparam exc_code_t EXC_RI   = 5'd10;
   localparam exc_code_t EXC_OV   = 5'd12;

   // reset and fixed values
   localparam word_t STATUS_RESET = 32'h0040_0000;  // bev set
   localparam word_t PRID_VALUE   = 32'h004c_0102;
   localparam word_t CONFIG_VALUE = 32'h0000_8000;

   // writable status bits, im7..0 exl ie
   localparam word_t STATUS_WMASK = 32'h0000_ff03;

   // general exception vector with bev=1
   localparam word_t HANDLER_PC = 32'hbfc0_0380;

endpackage
